/* lsp_config.svh */
`ifndef LSP_CONFIG_SVH
`define LSP_CONFIG_SVH

////////////////////////////////////////
// LSP vector geometry
////////////////////////////////////////

// Coefficients per LSP vector (G.729 order M)
`define LSP_ORDER 10

// Scratch memory address width, covers 0..LSP_ORDER-1
`define LSP_ADDR_BITS 4

`endif

/* lspPkg.sv */
`default_nettype none
`include "lsp_config.svh"

package lspPkg;

	////////////////////////////////////////
	// Coefficient word
	////////////////////////////////////////

	typedef logic signed [15:0] lspWord_t;	// Q15 LSP coefficient

	////////////////////////////////////////
	// Scratch memory ports
	////////////////////////////////////////

	typedef struct packed
	{
		logic en;
		logic [`LSP_ADDR_BITS-1:0] addr;
		lspWord_t data;
	} ramWrite_t;

	typedef struct packed
	{
		logic en;
		logic [`LSP_ADDR_BITS-1:0] addr;	// Data shows up one cycle later
	} ramRead_t;

	////////////////////////////////////////
	// Basic operator bundle
	////////////////////////////////////////

	typedef struct packed
	{
		lspWord_t subA;	// sub(a, b)
		lspWord_t subB;
		lspWord_t addA;	// add(a, b)
		lspWord_t addB;
		lspWord_t shrValue;	// shr(value, count)
		lspWord_t shrCount;
	} opRequest_t;

	typedef struct packed
	{
		lspWord_t subResult;
		lspWord_t addResult;
		lspWord_t shrResult;
	} opResult_t;

endpackage

`default_nettype wire

/* lspBasicOps.sv */
`timescale 1ns/1ps
`default_nettype none

module lspBasicOps
(
	input wire lspPkg::opRequest_t request,
	output lspPkg::opResult_t result
);
	import lspPkg::*;

	logic signed [16:0] subWide;	// One guard bit above the word
	logic signed [16:0] addWide;
	lspWord_t shrIn;	// Local copy keeps the shift arithmetic

	// Clamp a 17-bit result into the signed 16-bit range
	function automatic lspWord_t saturate(input logic signed [16:0] wide);
		if (wide > 17'sd32767)
			return 16'sh7fff;	// MAX_16
		else if (wide < -17'sd32768)
			return 16'sh8000;	// MIN_16
		else
			return wide[15:0];
	endfunction

	////////////////////////////////////////
	// sub, add and shr operators
	////////////////////////////////////////

	always_comb
	begin
		// Sign-extend both operands before the wide arithmetic
		subWide = {request.subA[15], request.subA} - {request.subB[15], request.subB};
		addWide = {request.addA[15], request.addA} + {request.addB[15], request.addB};
		shrIn = request.shrValue;

		result.subResult = saturate(subWide);
		result.addResult = saturate(addWide);
		result.shrResult = shrIn >>> request.shrCount[3:0];	// Sign fills from the left
	end

	// Only right shifts of 0..15 are ever requested by the FSM
	always_comb
	begin
		shiftRange: assert (request.shrCount >= 16'sd0 && request.shrCount < 16'sd16)
			else $error("lspBasicOps: shift count %0d out of range", request.shrCount);
	end

endmodule

`default_nettype wire

/* lspLoader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsp_config.svh"

module lspLoader
(
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire lspPkg::lspWord_t inWord,
	input wire logic busy,
	output lspPkg::ramWrite_t ramWr,
	output logic vectorReady
);
	localparam logic [`LSP_ADDR_BITS-1:0] lastAddr = `LSP_ORDER - 1;

	logic [`LSP_ADDR_BITS-1:0] count;	// Next free slot
	logic accept;
	logic lastWord;

	assign accept = inValid && !busy;	// Drop strobes during expand and unload
	assign lastWord = (count == lastAddr);

	// Accepted word goes straight to the memory on this edge
	always_comb
	begin
		ramWr.en = accept;
		ramWr.addr = count;
		ramWr.data = inWord;
	end

	////////////////////////////////////////
	// Word counter and ready pulse
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			vectorReady <= 1'b0;
		end
		else
		begin
			vectorReady <= accept && lastWord;	// One cycle, right after word 9
			if (accept)
				count <= lastWord ? '0 : count + 1'b1;	// Wrap for the next vector
		end
	end

endmodule

`default_nettype wire

/* lspScratchRam.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsp_config.svh"

module lspScratchRam
(
	input wire logic clk,
	input wire lspPkg::ramWrite_t loadWr,
	input wire lspPkg::ramWrite_t fsmWr,
	input wire lspPkg::ramRead_t fsmRd,
	input wire lspPkg::ramRead_t unloadRd,
	output lspPkg::lspWord_t readData
);
	import lspPkg::*;

	lspWord_t mem [`LSP_ORDER];	// One LSP vector

	// Phases never overlap, so a simple priority mux is enough
	always_ff @(posedge clk)
	begin
		if (loadWr.en)
			mem[loadWr.addr] <= loadWr.data;
		else if (fsmWr.en)
			mem[fsmWr.addr] <= fsmWr.data;
	end

	always_ff @(posedge clk)
	begin
		if (fsmRd.en)
			readData <= mem[fsmRd.addr];	// Shared registered output
		else if (unloadRd.en)
			readData <= mem[unloadRd.addr];
	end

	////////////////////////////////////////
	// Phase overlap checks
	////////////////////////////////////////

	writeCollision: assert property (@(posedge clk) !(loadWr.en && fsmWr.en))
		else $error("lspScratchRam: loader and FSM write in the same cycle");

	readCollision: assert property (@(posedge clk) !(fsmRd.en && unloadRd.en))
		else $error("lspScratchRam: FSM and unloader read in the same cycle");

endmodule

`default_nettype wire

/* lspExpandFsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsp_config.svh"

module lspExpandFsm
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic unloadLast,
	input wire logic [3:0] gap,
	input wire lspPkg::lspWord_t readData,
	input wire lspPkg::opResult_t opResult,
	output lspPkg::ramRead_t ramRd,
	output lspPkg::ramWrite_t ramWr,
	output lspPkg::opRequest_t opRequest,
	output logic expandDone,
	output logic busy
);
	import lspPkg::*;

	typedef enum logic [2:0] {INIT, LOOP, BODY1, BODY2, BODY3, BODY4} fsmState_t;

	fsmState_t state, nextState;
	logic [`LSP_ADDR_BITS-1:0] j, nextJ;	// Loop index 1..LSP_ORDER
	logic shiftDone, nextShiftDone;	// Second half of BODY4
	logic wrPending, nextWrPending;	// buf[j-1] still to be written
	logic busyReg;
	lspWord_t bufPrev, nextPrev;	// buf[j-1]
	lspWord_t bufCur, nextCur;	// buf[j]
	lspWord_t temp, nextTemp;	// diff, then sum, then tmp

	assign busy = busyReg || start;	// High from the ready pulse on

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= INIT;
			j <= 4'd1;
			shiftDone <= 1'b0;
			wrPending <= 1'b0;
			busyReg <= 1'b0;
		end
		else
		begin
			state <= nextState;
			j <= nextJ;
			shiftDone <= nextShiftDone;
			wrPending <= nextWrPending;
			if (start)
				busyReg <= 1'b1;
			else if (unloadLast)
				busyReg <= 1'b0;	// Released with the last streamed word
		end
	end

	always_ff @(posedge clk)
	begin
		bufPrev <= nextPrev;
		bufCur <= nextCur;
		temp <= nextTemp;
	end

	// Operator inputs come from registers only
	always_comb
	begin
		opRequest = '0;
		case (state)
			BODY2:
			begin
				opRequest.subA = bufPrev;	// diff = sub(buf[j-1], buf[j])
				opRequest.subB = readData;
			end
			BODY3:
			begin
				opRequest.addA = temp;	// add(diff, gap)
				opRequest.addB = {12'd0, gap};
			end
			BODY4:
				if (!shiftDone)
				begin
					opRequest.shrValue = temp;	// tmp = shr(sum, 1)
					opRequest.shrCount = 16'sd1;
				end
				else
				begin
					opRequest.subA = bufPrev;	// buf[j-1] - tmp
					opRequest.subB = temp;
					opRequest.addA = bufCur;	// buf[j] + tmp
					opRequest.addB = temp;
				end
			default: opRequest = '0;
		endcase
	end

	////////////////////////////////////////
	// Next state and memory access
	////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextJ = j;
		nextShiftDone = shiftDone;
		nextWrPending = wrPending;
		nextPrev = bufPrev;
		nextCur = bufCur;
		nextTemp = temp;
		ramRd = '0;
		ramWr = '0;
		expandDone = 1'b0;

		case (state)
			INIT:
				if (start)
				begin
					nextJ = 4'd1;
					nextShiftDone = 1'b0;
					nextState = LOOP;
				end
			LOOP:
			begin
				if (wrPending)
				begin
					ramWr.en = 1'b1;	// Deferred buf[j-1] of the previous pair
					ramWr.addr = j - 4'd2;
					ramWr.data = bufPrev;
					nextWrPending = 1'b0;
				end
				if (j >= `LSP_ORDER)
				begin
					expandDone = 1'b1;
					nextState = INIT;
				end
				else
				begin
					ramRd.en = 1'b1;	// Fetch buf[j-1]
					ramRd.addr = j - 4'd1;
					nextState = BODY1;
				end
			end
			BODY1:
			begin
				nextPrev = readData;
				ramRd.en = 1'b1;	// Fetch buf[j]
				ramRd.addr = j;
				nextState = BODY2;
			end
			BODY2:
			begin
				nextCur = readData;
				nextTemp = opResult.subResult;
				nextState = BODY3;
			end
			BODY3:
				// Arithmetic shift keeps the sign so the sum decides
				if (opResult.addResult[15])
				begin
					nextJ = j + 4'd1;	// Pair already far enough apart
					nextState = LOOP;
				end
				else
				begin
					nextTemp = opResult.addResult;
					nextShiftDone = 1'b0;
					nextState = BODY4;
				end
			BODY4:
				if (!shiftDone)
				begin
					nextTemp = opResult.shrResult;	// tmp held for both updates
					nextShiftDone = 1'b1;
				end
				else
				begin
					ramWr.en = 1'b1;	// Write buf[j] now for the next LOOP read
					ramWr.addr = j;
					ramWr.data = opResult.addResult;
					nextPrev = opResult.subResult;	// buf[j-1] written in LOOP
					nextWrPending = 1'b1;
					nextShiftDone = 1'b0;
					nextJ = j + 4'd1;
					nextState = LOOP;
				end
			default: nextState = INIT;
		endcase
	end

	jBound: assert property (@(posedge clk) disable iff (reset) j <= `LSP_ORDER)
		else $error("lspExpandFsm: loop index %0d past the vector", j);

endmodule

`default_nettype wire

/* lspUnloader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsp_config.svh"

module lspUnloader
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire lspPkg::lspWord_t readData,
	output lspPkg::ramRead_t ramRd,
	output logic outValid,
	output lspPkg::lspWord_t outWord,
	output logic [`LSP_ADDR_BITS-1:0] outIndex,
	output logic outLast
);
	localparam logic [`LSP_ADDR_BITS-1:0] lastAddr = `LSP_ORDER - 1;

	logic active;	// Reads in flight
	logic [`LSP_ADDR_BITS-1:0] count;

	always_comb
	begin
		ramRd.en = active;
		ramRd.addr = count;
	end

	assign outWord = readData;	// Lines up with outValid

	////////////////////////////////////////
	// Read sequencer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			count <= '0;
			outValid <= 1'b0;
			outLast <= 1'b0;
		end
		else
		begin
			outValid <= active;	// Data valid one cycle after the read
			outLast <= active && (count == lastAddr);
			if (start)
			begin
				active <= 1'b1;
				count <= '0;
			end
			else if (active)
			begin
				if (count == lastAddr)
					active <= 1'b0;
				count <= (count == lastAddr) ? '0 : count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
		outIndex <= count;	// Delayed with the read data

endmodule

`default_nettype wire

/* lspExpandTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsp_config.svh"

module lspExpandTop
(
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire lspPkg::lspWord_t inWord,
	input wire logic [3:0] gap,
	output logic outValid,
	output lspPkg::lspWord_t outWord,
	output logic [`LSP_ADDR_BITS-1:0] outIndex,
	output logic outLast,
	output logic busy
);
	import lspPkg::*;

	ramWrite_t loadWr;	// Loader write port
	ramWrite_t fsmWr;	// FSM write port
	ramRead_t fsmRd;
	ramRead_t unloadRd;
	lspWord_t readData;	// Shared by both readers
	opRequest_t opRequest;
	opResult_t opResult;
	logic vectorReady;
	logic expandDone;

	////////////////////////////////////////
	// Load, expand, unload
	////////////////////////////////////////

	lspLoader i_lspLoader
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inWord(inWord),
		.busy(busy),
		.ramWr(loadWr),
		.vectorReady(vectorReady)
	);

	lspScratchRam i_lspScratchRam
	(
		.clk(clk),
		.loadWr(loadWr),
		.fsmWr(fsmWr),
		.fsmRd(fsmRd),
		.unloadRd(unloadRd),
		.readData(readData)
	);

	lspExpandFsm i_lspExpandFsm
	(
		.clk(clk),
		.reset(reset),
		.start(vectorReady),
		.unloadLast(outLast),	// Ends the busy window
		.gap(gap),
		.readData(readData),
		.opResult(opResult),
		.ramRd(fsmRd),
		.ramWr(fsmWr),
		.opRequest(opRequest),
		.expandDone(expandDone),
		.busy(busy)
	);

	lspBasicOps i_lspBasicOps
	(
		.request(opRequest),
		.result(opResult)
	);

	lspUnloader i_lspUnloader
	(
		.clk(clk),
		.reset(reset),
		.start(expandDone),
		.readData(readData),
		.ramRd(unloadRd),
		.outValid(outValid),
		.outWord(outWord),
		.outIndex(outIndex),
		.outLast(outLast)
	);

endmodule

`default_nettype wire

/* tbLspExpand.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lsp_config.svh"

module tbLspExpand;
	import lspPkg::*;

	localparam int NUM_DIRECTED = 8;
	localparam int NUM_ROWS = 20;	// Directed rows followed by random ones
	localparam int CYCLE_LIMIT = NUM_ROWS * 90;	// About 82 cycles per worst-case row

	logic clk;
	logic reset;
	logic inValid;
	lspWord_t inWord;
	logic [3:0] gap;
	logic outValid;
	lspWord_t outWord;
	logic [`LSP_ADDR_BITS-1:0] outIndex;
	logic outLast;
	logic busy;

	int stimTable [NUM_ROWS][`LSP_ORDER];	// Coefficients as loaded
	logic [3:0] gapTable [NUM_ROWS];
	lspWord_t expTable [NUM_ROWS][`LSP_ORDER];	// Reference model output
	int errorCount;
	int checkCount;
	int cycleCount;

	lspExpandTop i_lspExpandTop
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inWord(inWord),
		.gap(gap),
		.outValid(outValid),
		.outWord(outWord),
		.outIndex(outIndex),
		.outLast(outLast),
		.busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	// Run limit
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Signed 16-bit clamp
	function automatic lspWord_t clampWord(input int value);
		if (value > 32767)
			return 16'sh7fff;
		else if (value < -32768)
			return 16'sh8000;
		else
			return lspWord_t'(value);
	endfunction

	// Spacing rule applied pair by pair on the running vector
	task automatic expandModel(input int r);
		lspWord_t c [`LSP_ORDER];
		lspWord_t diff;
		lspWord_t sum;
		lspWord_t tmp;
		for (int k = 0; k < `LSP_ORDER; k++)
			c[k] = lspWord_t'(stimTable[r][k]);
		for (int j = 1; j < `LSP_ORDER; j++)
		begin
			diff = clampWord(int'(c[j-1]) - int'(c[j]));
			sum = clampWord(int'(diff) + int'(gapTable[r]));	// Gap is unsigned
			tmp = sum >>> 1;
			if (tmp >= 0)
			begin
				c[j-1] = clampWord(int'(c[j-1]) - int'(tmp));
				c[j] = clampWord(int'(c[j]) + int'(tmp));
			end
		end
		for (int k = 0; k < `LSP_ORDER; k++)
			expTable[r][k] = c[k];
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	task automatic fillTable();
		logic [31:0] rnd;
		// Ascending and well apart so nothing moves
		stimTable[0] = '{1000, 3000, 5000, 7000, 9000, 11000, 13000, 15000, 17000, 19000};
		gapTable[0] = 0;
		stimTable[1] = '{1000, 3000, 5000, 7000, 9000, 11000, 13000, 15000, 17000, 19000};
		gapTable[1] = 7;
		stimTable[2] = '{2000, 2010, 2005, 3000, 2990, 4000, 4100, 4050, 6000, 5000};
		gapTable[2] = 0;
		stimTable[3] = '{1000, 1002, 1004, 1006, 1008, 1010, 1012, 1014, 1016, 1018};
		gapTable[3] = 7;	// Tight pairs cascade down the vector
		stimTable[4] = '{9000, 8000, 7000, 6000, 5000, 4000, 3000, 2000, 1000, 0};
		gapTable[4] = 15;
		// Full-scale swings saturate diff
		stimTable[5] = '{32767, -32768, 32767, -32768, 32767, -32768, 32767, -32768, 32767,
			-32768};
		gapTable[5] = 15;
		stimTable[6] = '{32767, 32767, 32000, 32767, 30000, -32768, -32768, -30000, -32768, 100};
		gapTable[6] = 7;
		stimTable[7] = '{-32768, -32768, -32768, 32767, 32767, 32767, 0, 0, -32768, 32767};
		gapTable[7] = 15;	// Updates clamp at both rails
		for (int r = NUM_DIRECTED; r < NUM_ROWS; r++)
		begin
			rnd = $urandom;
			gapTable[r] = rnd[3:0];
			for (int k = 0; k < `LSP_ORDER; k++)
			begin
				rnd = $urandom;
				if (r % 2 == 0)
					stimTable[r][k] = int'($signed(rnd[15:0]));	// Full range
				else
					stimTable[r][k] = int'(rnd[7:0]) - 128;	// Crowded values where most pairs move
			end
		end
	endtask

	////////////////////////////////////////
	// Load a row and collect the stream
	////////////////////////////////////////

	task automatic applyRow(input int r);
		int got;
		int errorsBefore;
		logic [31:0] junk;
		errorsBefore = errorCount;
		got = 0;
		gap = gapTable[r];
		for (int k = 0; k < `LSP_ORDER; k++)
		begin
			@(negedge clk);
			if (busy || outValid)
			begin
				errorCount++;
				$display("Row %0d: busy or outValid high while loading word %0d", r, k);
			end
			inValid = 1'b1;
			inWord = lspWord_t'(stimTable[r][k]);
		end
		do
		begin
			@(negedge clk);	// Outputs settled since the rising edge
			if (outValid && got >= `LSP_ORDER)
			begin
				errorCount++;
				$display("Row %0d: extra word after the tenth", r);
			end
			else if (outValid)
			begin
				checkCount++;
				if (outWord !== expTable[r][got])
				begin
					errorCount++;
					$display("Mismatch outWord index %0d: expected %h got %h", got,
						expTable[r][got], outWord);
				end
				if (outIndex !== 4'(got))
				begin
					errorCount++;
					$display("Mismatch outIndex: expected %h got %h", 4'(got), outIndex);
				end
				if (outLast !== (got == `LSP_ORDER - 1))
				begin
					errorCount++;
					$display("Mismatch outLast index %0d: expected %h got %h", got,
						(got == `LSP_ORDER - 1), outLast);
				end
				got++;
			end
			else if (got > 0 && got < `LSP_ORDER)
			begin
				errorCount++;
				$display("Row %0d: stream paused after %0d words", r, got);
			end
			else if (got == `LSP_ORDER && busy)
			begin
				errorCount++;
				$display("Row %0d: busy still high after the last word", r);
			end
			// Junk strobes while busy get dropped by the loader
			if (busy)
			begin
				junk = $urandom;
				inValid = junk[16];
				inWord = junk[15:0];
			end
			else
				inValid = 1'b0;
		end
		while (busy);
		if (got != `LSP_ORDER)
		begin
			errorCount++;
			$display("Row %0d: only %0d of 10 words came out", r, got);
		end
		$display("Row %0d gap %0d: %0d words, %0d errors", r, gapTable[r], got,
			errorCount - errorsBefore);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inWord = '0;
		gap = '0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		void'($urandom(32'h01b0_6678));
		fillTable();
		for (int r = 0; r < NUM_ROWS; r++)
			expandModel(r);
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Idle outputs before any vector
		repeat (4)
		begin
			@(negedge clk);
			if (outValid || outLast || busy)
			begin
				errorCount++;
				$display("Outputs active after reset with no vector loaded");
			end
		end
		for (int r = 0; r < NUM_ROWS; r++)
			applyRow(r);
		$display("Rows: %0d, words checked: %0d, errors: %0d", NUM_ROWS, checkCount,
			errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
lspPkg.sv
lspBasicOps.sv
lspLoader.sv
lspScratchRam.sv
lspExpandFsm.sv
lspUnloader.sv
lspExpandTop.sv
tbLspExpand.sv

/* Makefile */
TOP = tbLspExpand

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
